// ==== verilog/isaPkg.sv ====
package isaPkg;

  localparam int OpcodeWidth = 6;
  localparam int FunctWidth = 6;

  // Opcodes
  localparam logic [OpcodeWidth-1:0] OpTypeR = 6'h00;
  localparam logic [OpcodeWidth-1:0] OpJ = 6'h02;
  localparam logic [OpcodeWidth-1:0] OpJal = 6'h03;
  localparam logic [OpcodeWidth-1:0] OpBeq = 6'h04;
  localparam logic [OpcodeWidth-1:0] OpBne = 6'h05;
  localparam logic [OpcodeWidth-1:0] OpBle = 6'h06;
  localparam logic [OpcodeWidth-1:0] OpBgt = 6'h07;
  localparam logic [OpcodeWidth-1:0] OpAddi = 6'h08;
  localparam logic [OpcodeWidth-1:0] OpAddiu = 6'h09;
  localparam logic [OpcodeWidth-1:0] OpLb = 6'h20;
  localparam logic [OpcodeWidth-1:0] OpLh = 6'h21;
  localparam logic [OpcodeWidth-1:0] OpLw = 6'h23;
  localparam logic [OpcodeWidth-1:0] OpSb = 6'h28;
  localparam logic [OpcodeWidth-1:0] OpSh = 6'h29;
  localparam logic [OpcodeWidth-1:0] OpSw = 6'h2B;

  // Funct codes under OpTypeR
  localparam logic [FunctWidth-1:0] FunJr = 6'h08;
  localparam logic [FunctWidth-1:0] FunMult = 6'h18;
  localparam logic [FunctWidth-1:0] FunDiv = 6'h1A;
  localparam logic [FunctWidth-1:0] FunAdd = 6'h20;
  localparam logic [FunctWidth-1:0] FunSub = 6'h22;
  localparam logic [FunctWidth-1:0] FunAnd = 6'h24;

  typedef struct packed {
    logic [OpcodeWidth-1:0] opcode;
    logic [FunctWidth-1:0] funct;
  } instrFields;

  typedef struct packed {
    logic overflow;
    logic zero;
  } dpFlags;

  typedef enum logic [3:0] {
    clsAluReg, clsAluImm,
    clsLoad, clsStore,
    clsBranch,
    clsJump, clsJumpLink, clsJumpReg,
    clsMult, clsDiv,
    clsInvalid
  } instrClass;

  // funcAddU is the add that ignores overflow
  typedef enum logic [1:0] {
    funcAdd = 2'd0,
    funcAnd = 2'd1,
    funcSub = 2'd2,
    funcAddU = 2'd3
  } aluFunc;

  typedef enum logic [1:0] {
    sizeNone = 2'd0,
    sizeByte = 2'd1,
    sizeHalf = 2'd2,
    sizeWord = 2'd3
  } memSize;

  typedef enum logic [1:0] {
    condNe = 2'd0,
    condEq = 2'd1,
    condLe = 2'd2,
    condGt = 2'd3
  } branchCond;

  typedef struct packed {
    instrClass kind;
    aluFunc aluFn;
    memSize size;
    branchCond cond;
  } decodedInstr;

endpackage

// ==== verilog/ctrlPkg.sv ====
package ctrlPkg;

  // Cycles spent in multWait
  localparam int MultWaitCycles = 33;
  localparam int MultCountWidth = 6;

  typedef enum logic [4:0] {
    stFetch, stWaitMem, stDecode,
    stAluExec, stAluWrite,
    stOvfVector, stOvfJump,
    stAddrCalc, stLoadRead, stLoadWrite, stStoreWrite,
    stBranchEval,
    stJumpLinkCalc, stJumpLinkWrite, stJumpWrite,
    stJumpRegCalc, stJumpRegWrite,
    stMultWait,
    stDivCheck, stDivZeroVector, stDivZeroJump,
    stInvalidVector, stInvalidJump
  } ctrlState;

  typedef enum logic [1:0] {
    pcIncrement = 2'd0,
    pcJumpTarget = 2'd1,
    pcMemVector = 2'd2,
    pcAluOut = 2'd3
  } pcSrc;

  typedef enum logic [2:0] {
    addrPc = 3'd0,
    addrAluOut = 3'd1,
    addrInvalidVector = 3'd2,
    addrOverflowVector = 3'd3,
    addrDivZeroVector = 3'd4
  } addrSrc;

  typedef enum logic [1:0] {
    srcBReg = 2'd0,
    srcBImmediate = 2'd1,
    srcBBranchOffset = 2'd2,
    srcBFour = 2'd3
  } aluSrcBSel;

  // Link writes r31
  typedef enum logic [1:0] {
    dstRt = 2'd0,
    dstRd = 2'd1,
    dstLink = 2'd3
  } regDstSel;

  typedef enum logic {
    wbAluOut = 1'b0,
    wbMemData = 1'b1
  } wbSrc;

  typedef enum logic [2:0] {
    aluPassA = 3'd0,
    aluAdd = 3'd1,
    aluSub = 3'd2,
    aluAnd = 3'd3,
    aluCompare = 3'd7
  } aluOpSel;

  typedef enum logic {
    mdDiv = 1'b0,
    mdMult = 1'b1
  } mulDivOp;

  typedef struct packed {
    logic pcWrite;
    logic pcWriteCond;
    isaPkg::branchCond condSel;
    pcSrc pcSource;
    logic memRead;
    logic memWrite;
    addrSrc memAddrSel;
    isaPkg::memSize lsSize;
    logic irWrite;
    logic regWrite;
    regDstSel regDst;
    wbSrc memToReg;
    aluOpSel aluOp;
    logic aluSrcA;
    aluSrcBSel aluSrcB;
    logic mulDivStart;
    mulDivOp mulDivSel;
  } controlWord;

endpackage

// ==== verilog/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder (
  input isaPkg::instrFields instr,
  output isaPkg::decodedInstr decoded
);

  import isaPkg::*;

  always_comb begin
    decoded = '0;

    // Class from opcode, funct only for R-type
    case (instr.opcode)
      OpTypeR: begin
        case (instr.funct)
          FunAdd, FunAnd, FunSub: decoded.kind = clsAluReg;
          FunJr: decoded.kind = clsJumpReg;
          FunMult: decoded.kind = clsMult;
          FunDiv: decoded.kind = clsDiv;
          default: decoded.kind = clsInvalid;
        endcase
      end
      OpAddi, OpAddiu: decoded.kind = clsAluImm;
      OpBeq, OpBne, OpBle, OpBgt: decoded.kind = clsBranch;
      OpLb, OpLh, OpLw: decoded.kind = clsLoad;
      OpSb, OpSh, OpSw: decoded.kind = clsStore;
      OpJ: decoded.kind = clsJump;
      OpJal: decoded.kind = clsJumpLink;
      default: decoded.kind = clsInvalid;
    endcase

    // Sub-fields, left at zero where the class has none
    case (decoded.kind)
      clsAluReg: begin
        case (instr.funct)
          FunSub: decoded.aluFn = funcSub;
          FunAnd: decoded.aluFn = funcAnd;
          default: decoded.aluFn = funcAdd;
        endcase
      end
      clsAluImm: begin
        decoded.aluFn = (instr.opcode == OpAddiu) ? funcAddU : funcAdd;
      end
      clsBranch: begin
        case (instr.opcode)
          OpBeq: decoded.cond = condEq;
          OpBne: decoded.cond = condNe;
          OpBle: decoded.cond = condLe;
          default: decoded.cond = condGt;
        endcase
      end
      clsLoad, clsStore: begin
        // Low opcode bits give the width for both loads and stores
        case (instr.opcode[1:0])
          2'b00: decoded.size = sizeByte;
          2'b01: decoded.size = sizeHalf;
          default: decoded.size = sizeWord;
        endcase
      end
      default: ;
    endcase
  end

endmodule

// ==== verilog/stateSequencer.sv ====
`timescale 1ns/1ps

module stateSequencer (
  input logic clk,
  input logic reset_in,
  input isaPkg::decodedInstr decoded,
  input isaPkg::dpFlags flags,
  output ctrlPkg::ctrlState state,
  output isaPkg::decodedInstr heldInstr
);

  import isaPkg::*;
  import ctrlPkg::*;

  ctrlState nextState;
  logic [MultCountWidth-1:0] multCount;
  logic multDone;
  logic ovfTrap;

  assign multDone = (multCount == MultCountWidth'(MultWaitCycles - 1));

  // addiu decodes as funcAddU and never traps
  assign ovfTrap = flags.overflow && (heldInstr.aluFn inside {funcAdd, funcSub});

  always_comb begin
    nextState = stFetch;
    case (state)
      stFetch: nextState = stWaitMem;
      stWaitMem: nextState = stDecode;
      stDecode: begin
        case (decoded.kind)
          clsAluReg, clsAluImm: nextState = stAluExec;
          clsLoad, clsStore: nextState = stAddrCalc;
          clsBranch: nextState = stBranchEval;
          clsJump: nextState = stJumpWrite;
          clsJumpLink: nextState = stJumpLinkCalc;
          clsJumpReg: nextState = stJumpRegCalc;
          clsMult: nextState = stMultWait;
          clsDiv: nextState = stDivCheck;
          default: nextState = stInvalidVector;
        endcase
      end
      stAluExec: nextState = stAluWrite;
      stAluWrite: nextState = ovfTrap ? stOvfVector : stFetch;
      stOvfVector: nextState = stOvfJump;
      stAddrCalc: nextState = (heldInstr.kind == clsLoad) ? stLoadRead : stStoreWrite;
      stLoadRead: nextState = stLoadWrite;
      stJumpLinkCalc: nextState = stJumpLinkWrite;
      stJumpLinkWrite: nextState = stJumpWrite;
      stJumpRegCalc: nextState = stJumpRegWrite;
      stMultWait: nextState = multDone ? stFetch : stMultWait;
      stDivCheck: nextState = flags.zero ? stDivZeroVector : stFetch;
      stDivZeroVector: nextState = stDivZeroJump;
      stInvalidVector: nextState = stInvalidJump;
      // Terminal states
      default: nextState = stFetch;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_in) begin
      state <= stFetch;
      multCount <= '0;
    end else begin
      state <= nextState;
      // Zero outside multWait, so every entry starts the count afresh
      if (state == stMultWait) begin
        multCount <= multCount + 1'b1;
      end else begin
        multCount <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == stDecode) begin
      heldInstr <= decoded;
    end else if (state == stMultWait) begin
      // Retire the held decode once the multiplier is started
      heldInstr <= '0;
    end
  end

  multWaitBound: assert property (@(posedge clk) disable iff (reset_in)
    $rose(state == stMultWait) |-> ##[1:MultWaitCycles] (state != stMultWait))
    else $error("multWait lasted longer than %0d cycles", MultWaitCycles);

  decodeToClass: assert property (@(posedge clk) disable iff (reset_in)
    (state == stDecode) |=> (state inside {stAluExec, stAddrCalc, stBranchEval,
      stJumpWrite, stJumpLinkCalc, stJumpRegCalc, stMultWait, stDivCheck,
      stInvalidVector}))
    else $error("decode not followed by a class state");

  terminalToFetch: assert property (@(posedge clk) disable iff (reset_in)
    (state inside {stLoadWrite, stStoreWrite, stBranchEval, stJumpWrite,
      stJumpRegWrite, stOvfJump, stDivZeroJump, stInvalidJump}) |=> (state == stFetch))
    else $error("terminal state did not return to fetch");

endmodule

// ==== verilog/controlEncoder.sv ====
`timescale 1ns/1ps

module controlEncoder (
  input logic reset_in,
  input ctrlPkg::ctrlState state,
  input isaPkg::decodedInstr heldInstr,
  output ctrlPkg::controlWord ctrl
);

  import isaPkg::*;
  import ctrlPkg::*;

  always_comb begin
    ctrl = '0;
    case (state)
      stFetch: begin
        ctrl.memRead = 1'b1;
        ctrl.irWrite = 1'b1;
        ctrl.memAddrSel = addrPc;
        ctrl.pcWrite = 1'b1;
        ctrl.pcSource = pcIncrement;
        ctrl.aluSrcB = srcBFour;
        ctrl.aluOp = aluAdd;
      end
      // Branch target into ALUOut ahead of branchEval
      stDecode: begin
        ctrl.aluSrcB = srcBBranchOffset;
        ctrl.aluOp = aluAdd;
      end
      stAluExec: begin
        ctrl.aluSrcA = 1'b1;
        ctrl.aluSrcB = (heldInstr.kind == clsAluImm) ? srcBImmediate : srcBReg;
        case (heldInstr.aluFn)
          funcSub: ctrl.aluOp = aluSub;
          funcAnd: ctrl.aluOp = aluAnd;
          default: ctrl.aluOp = aluAdd;
        endcase
      end
      stAluWrite: begin
        ctrl.regWrite = 1'b1;
        ctrl.memToReg = wbAluOut;
        ctrl.regDst = (heldInstr.kind == clsAluImm) ? dstRt : dstRd;
      end
      stAddrCalc: begin
        ctrl.aluSrcA = 1'b1;
        ctrl.aluSrcB = srcBImmediate;
        ctrl.aluOp = aluAdd;
      end
      stLoadRead: begin
        ctrl.memRead = 1'b1;
        ctrl.memAddrSel = addrAluOut;
      end
      stLoadWrite: begin
        ctrl.regWrite = 1'b1;
        ctrl.regDst = dstRt;
        ctrl.memToReg = wbMemData;
        ctrl.lsSize = heldInstr.size;
      end
      stStoreWrite: begin
        ctrl.memWrite = 1'b1;
        ctrl.memAddrSel = addrAluOut;
        ctrl.lsSize = heldInstr.size;
      end
      stBranchEval: begin
        ctrl.pcWriteCond = 1'b1;
        ctrl.condSel = heldInstr.cond;
        ctrl.pcSource = pcAluOut;
        ctrl.aluSrcA = 1'b1;
        ctrl.aluSrcB = srcBReg;
        ctrl.aluOp = aluCompare;
      end
      // PC already points past the jal
      stJumpLinkCalc: ctrl.aluOp = aluPassA;
      stJumpLinkWrite: begin
        ctrl.regWrite = 1'b1;
        ctrl.regDst = dstLink;
        ctrl.memToReg = wbAluOut;
      end
      stJumpWrite: begin
        ctrl.pcWrite = 1'b1;
        ctrl.pcSource = pcJumpTarget;
      end
      stJumpRegCalc: begin
        ctrl.aluSrcA = 1'b1;
        ctrl.aluOp = aluPassA;
      end
      stJumpRegWrite: begin
        ctrl.pcWrite = 1'b1;
        ctrl.pcSource = pcAluOut;
      end
      // Held class is cleared after the first multWait cycle
      stMultWait: begin
        ctrl.mulDivStart = (heldInstr.kind == clsMult);
        ctrl.mulDivSel = mdMult;
      end
      stDivCheck: begin
        ctrl.mulDivStart = 1'b1;
        ctrl.mulDivSel = mdDiv;
      end
      stOvfVector: begin
        ctrl.memRead = 1'b1;
        ctrl.memAddrSel = addrOverflowVector;
      end
      stDivZeroVector: begin
        ctrl.memRead = 1'b1;
        ctrl.memAddrSel = addrDivZeroVector;
      end
      stInvalidVector: begin
        ctrl.memRead = 1'b1;
        ctrl.memAddrSel = addrInvalidVector;
      end
      stOvfJump, stDivZeroJump, stInvalidJump: begin
        ctrl.pcWrite = 1'b1;
        ctrl.pcSource = pcMemVector;
      end
      default: ctrl = '0;
    endcase

    // Strobes stay low while reset is held
    if (reset_in) begin
      ctrl = '0;
    end
  end

  memExclusive: assert #0 (!(ctrl.memRead && ctrl.memWrite))
    else $error("memRead and memWrite high together");

endmodule

// ==== verilog/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit (
  input logic clk,
  input logic reset_in,
  input isaPkg::instrFields instr,
  input isaPkg::dpFlags flags,
  output ctrlPkg::controlWord ctrl
);

  import isaPkg::*;
  import ctrlPkg::*;

  decodedInstr decoded;
  decodedInstr heldInstr;
  ctrlState state;

  instrDecoder instrDecoder_i (
    .instr(instr),
    .decoded(decoded)
  );

  stateSequencer stateSequencer_i (
    .clk(clk),
    .reset_in(reset_in),
    .decoded(decoded),
    .flags(flags),
    .state(state),
    .heldInstr(heldInstr)
  );

  controlEncoder controlEncoder_i (
    .reset_in(reset_in),
    .state(state),
    .heldInstr(heldInstr),
    .ctrl(ctrl)
  );

endmodule

// ==== testbench/controlUnitProps.sv ====
`timescale 1ns/1ps

module controlUnitProps (
  input logic clk,
  input logic reset_in,
  input isaPkg::dpFlags flags,
  input ctrlPkg::controlWord ctrl,
  input isaPkg::decodedInstr expInstr,
  output logic checkFailed
);

  import isaPkg::*;
  import ctrlPkg::*;

  logic started;
  logic trap;
  logic vectorRead;
  int cycles;
  int regWrites;
  int pcWrites;
  int memWrites;
  int mulDivStarts;
  int expLength;
  int expRegWrites;
  int expPcWrites;
  int expMemWrites;
  int expMulDivStarts;
  aluOpSel expAluOp;
  addrSrc expVector;

  function automatic int instrLength(decodedInstr d, logic trapped);
    int len;
    case (d.kind)
      clsLoad, clsJumpLink: len = 6;
      clsMult: len = 3 + MultWaitCycles;
      clsBranch, clsJump, clsDiv: len = 4;
      default: len = 5;
    endcase
    // Vector read and jump; invalid already counts them
    if (trapped && d.kind != clsInvalid) begin
      len = len + 2;
    end
    return len;
  endfunction

  task automatic reportViolation(input string msg);
    $display("** Error at %0d ns: %s", $time, msg);
    checkFailed = 1'b1;
  endtask

  initial checkFailed = 1'b0;

  // addiu never traps on overflow
  assign trap = (expInstr.kind == clsInvalid) || (expInstr.kind == clsDiv && flags.zero)
    || (expInstr.kind inside {clsAluReg, clsAluImm} && flags.overflow
      && expInstr.aluFn inside {funcAdd, funcSub});
  assign expLength = instrLength(expInstr, trap);
  assign expRegWrites = (expInstr.kind inside {clsAluReg, clsAluImm, clsLoad, clsJumpLink}) ? 1 : 0;
  assign expPcWrites = (trap || expInstr.kind inside {clsBranch, clsJump, clsJumpLink,
    clsJumpReg}) ? 1 : 0;
  assign expMemWrites = (expInstr.kind == clsStore) ? 1 : 0;
  assign expMulDivStarts = (expInstr.kind inside {clsMult, clsDiv}) ? 1 : 0;
  assign expAluOp = (expInstr.aluFn == funcSub) ? aluSub
    : (expInstr.aluFn == funcAnd) ? aluAnd : aluAdd;
  assign expVector = (expInstr.kind == clsInvalid) ? addrInvalidVector
    : (expInstr.kind == clsDiv) ? addrDivZeroVector : addrOverflowVector;
  assign vectorRead = ctrl.memRead
    && (ctrl.memAddrSel inside {addrInvalidVector, addrOverflowVector, addrDivZeroVector});

  // Counts restart at every fetch
  always_ff @(posedge clk) begin
    if (reset_in) begin
      started <= 1'b0;
      cycles <= 0;
      regWrites <= 0;
      pcWrites <= 0;
      memWrites <= 0;
      mulDivStarts <= 0;
    end else if (ctrl.irWrite) begin
      started <= 1'b1;
      cycles <= 1;
      regWrites <= 0;
      pcWrites <= 0;
      memWrites <= 0;
      mulDivStarts <= 0;
    end else begin
      cycles <= cycles + 1;
      regWrites <= regWrites + (ctrl.regWrite ? 1 : 0);
      pcWrites <= pcWrites + ((ctrl.pcWrite || ctrl.pcWriteCond) ? 1 : 0);
      memWrites <= memWrites + (ctrl.memWrite ? 1 : 0);
      mulDivStarts <= mulDivStarts + (ctrl.mulDivStart ? 1 : 0);
    end
  end

  resetQuiet: assert property (@(posedge clk) reset_in |-> (ctrl == '0))
    else reportViolation("control strobes active during reset");

  firstFetch: assert property (@(posedge clk) $fell(reset_in) |->
    (ctrl.irWrite && ctrl.memRead && ctrl.pcWrite && ctrl.pcSource == pcIncrement))
    else reportViolation("first cycle after reset is not a fetch");

  lengthMatch: assert property (@(posedge clk) disable iff (reset_in)
    (ctrl.irWrite && started) |-> (cycles == $past(expLength)))
    else reportViolation($sformatf("instruction took %0d cycles", $sampled(cycles)));

  strobeCounts: assert property (@(posedge clk) disable iff (reset_in)
    (ctrl.irWrite && started) |-> (regWrites == $past(expRegWrites)
      && pcWrites == $past(expPcWrites) && memWrites == $past(expMemWrites)
      && mulDivStarts == $past(expMulDivStarts)))
    else reportViolation("wrong number of write strobes in an instruction");

  aluWriteback: assert property (@(posedge clk) disable iff (reset_in)
    (ctrl.regWrite && expInstr.kind inside {clsAluReg, clsAluImm}) |->
    (ctrl.memToReg == wbAluOut && $past(ctrl.aluOp) == expAluOp
      && ctrl.regDst == ((expInstr.kind == clsAluImm) ? dstRt : dstRd)))
    else reportViolation("arithmetic writeback or ALU operation mismatch");

  loadWriteback: assert property (@(posedge clk) disable iff (reset_in)
    (ctrl.regWrite && expInstr.kind == clsLoad) |->
    (ctrl.memToReg == wbMemData && ctrl.lsSize == expInstr.size
      && $past(ctrl.memRead && ctrl.memAddrSel == addrAluOut)))
    else reportViolation("load sequence mismatch");

  storeWrite: assert property (@(posedge clk) disable iff (reset_in)
    ctrl.memWrite |-> (expInstr.kind == clsStore && ctrl.lsSize == expInstr.size
      && ctrl.memAddrSel == addrAluOut))
    else reportViolation("store write mismatch");

  memExclusive: assert property (@(posedge clk) !(ctrl.memRead && ctrl.memWrite))
    else reportViolation("memRead and memWrite high together");

  branchCond: assert property (@(posedge clk) disable iff (reset_in)
    ctrl.pcWriteCond |-> (expInstr.kind == clsBranch && ctrl.condSel == expInstr.cond))
    else reportViolation("branch condition mismatch");

  jumpTarget: assert property (@(posedge clk) disable iff (reset_in)
    (ctrl.pcWrite && !ctrl.irWrite && expInstr.kind inside {clsJump, clsJumpLink, clsJumpReg})
    |-> (ctrl.pcSource == ((expInstr.kind == clsJumpReg) ? pcAluOut : pcJumpTarget)))
    else reportViolation("jump PC source mismatch");

  linkWrite: assert property (@(posedge clk) disable iff (reset_in)
    (ctrl.regWrite && expInstr.kind == clsJumpLink) |-> (ctrl.regDst == dstLink))
    else reportViolation("jal does not write the link register");

  mulDivKind: assert property (@(posedge clk) disable iff (reset_in)
    ctrl.mulDivStart |-> (expInstr.kind inside {clsMult, clsDiv}
      && ctrl.mulDivSel == ((expInstr.kind == clsMult) ? mdMult : mdDiv)))
    else reportViolation("multiply or divide start mismatch");

  vectorSelect: assert property (@(posedge clk) disable iff (reset_in)
    vectorRead |-> (trap && ctrl.memAddrSel == expVector))
    else reportViolation("unexpected or wrong trap vector read");

  vectorJump: assert property (@(posedge clk) disable iff (reset_in)
    vectorRead |=> (ctrl.pcWrite && ctrl.pcSource == pcMemVector))
    else reportViolation("trap vector read not followed by vector jump");

endmodule

// ==== testbench/controlUnitTb.sv ====
`timescale 1ns/1ps

module controlUnitTb;

  import isaPkg::*;
  import ctrlPkg::*;

  localparam int ClkPeriod = 4;
  localparam int InputDelay = 1;
  localparam int ResetCycles = 8;
  localparam int NumInstr = 300;
  // Every instruction as long as a mult
  localparam int TimeoutNs = (NumInstr * (3 + MultWaitCycles) + ResetCycles + 4) * ClkPeriod;

  // Two unused opcodes and two unused functs at the end
  localparam logic [OpcodeWidth-1:0] OpcodeMenu [16] = '{
    OpJ, OpJal, OpBeq, OpBne, OpBle, OpBgt, OpAddi, OpAddiu,
    OpLb, OpLh, OpLw, OpSb, OpSh, OpSw, 6'h0F, 6'h3F
  };
  localparam logic [FunctWidth-1:0] FunctMenu [8] = '{
    FunAdd, FunSub, FunAnd, FunJr, FunMult, FunDiv, 6'h2A, 6'h10
  };

  logic clk;
  logic reset_in;
  instrFields instr;
  dpFlags flags;
  controlWord ctrl;
  decodedInstr expInstr;
  logic checkFailed;
  logic [7:0] lfsr;
  int issued;

  // x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] nextLfsr(logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  task automatic drawBits(input int n, output logic [7:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = nextLfsr(lfsr);
      value = {value[6:0], lfsr[0]};
    end
  endtask

  // Straight from the encoding table
  function automatic decodedInstr expectedDecode(instrFields f);
    decodedInstr d;
    d = '{clsInvalid, funcAdd, sizeNone, condNe};
    case (f.opcode)
      OpTypeR: begin
        case (f.funct)
          FunAdd: d = '{clsAluReg, funcAdd, sizeNone, condNe};
          FunSub: d = '{clsAluReg, funcSub, sizeNone, condNe};
          FunAnd: d = '{clsAluReg, funcAnd, sizeNone, condNe};
          FunJr: d.kind = clsJumpReg;
          FunMult: d.kind = clsMult;
          FunDiv: d.kind = clsDiv;
          default: d.kind = clsInvalid;
        endcase
      end
      OpJ: d.kind = clsJump;
      OpJal: d.kind = clsJumpLink;
      OpBeq: d = '{clsBranch, funcAdd, sizeNone, condEq};
      OpBne: d = '{clsBranch, funcAdd, sizeNone, condNe};
      OpBle: d = '{clsBranch, funcAdd, sizeNone, condLe};
      OpBgt: d = '{clsBranch, funcAdd, sizeNone, condGt};
      OpAddi: d = '{clsAluImm, funcAdd, sizeNone, condNe};
      OpAddiu: d = '{clsAluImm, funcAddU, sizeNone, condNe};
      OpLb: d = '{clsLoad, funcAdd, sizeByte, condNe};
      OpLh: d = '{clsLoad, funcAdd, sizeHalf, condNe};
      OpLw: d = '{clsLoad, funcAdd, sizeWord, condNe};
      OpSb: d = '{clsStore, funcAdd, sizeByte, condNe};
      OpSh: d = '{clsStore, funcAdd, sizeHalf, condNe};
      OpSw: d = '{clsStore, funcAdd, sizeWord, condNe};
      default: d.kind = clsInvalid;
    endcase
    return d;
  endfunction

  task automatic presentNext();
    logic [7:0] pick;
    instrFields f;
    drawBits(1, pick);
    if (pick[0]) begin
      drawBits(3, pick);
      f.opcode = OpTypeR;
      f.funct = FunctMenu[pick[2:0]];
    end else begin
      drawBits(4, pick);
      f.opcode = OpcodeMenu[pick[3:0]];
      // Funct is noise outside R-type
      drawBits(6, pick);
      f.funct = pick[5:0];
    end
    instr = f;
    expInstr = expectedDecode(f);
    drawBits(2, pick);
    flags = dpFlags'(pick[1:0]);
    issued = issued + 1;
  endtask

  task automatic stopWithFailure(input string why);
    $display("Errors found");
    $fatal(1, "%s", why);
  endtask

  initial clk = 1'b0;
  always #(ClkPeriod / 2) clk = ~clk;

  controlUnit controlUnit_i (
    .clk(clk),
    .reset_in(reset_in),
    .instr(instr),
    .flags(flags),
    .ctrl(ctrl)
  );

  controlUnitProps controlUnitProps_i (
    .clk(clk),
    .reset_in(reset_in),
    .flags(flags),
    .ctrl(ctrl),
    .expInstr(expInstr),
    .checkFailed(checkFailed)
  );

  initial begin
    lfsr = 8'd59;
    issued = 0;
    reset_in = 1'b1;
    instr = '0;
    flags = '0;
    expInstr = '0;
    repeat (ResetCycles) @(posedge clk);
    #InputDelay;
    reset_in = 1'b0;
    presentNext();
    while (issued < NumInstr) begin
      @(posedge clk);
      #InputDelay;
      if (ctrl.irWrite) begin
        presentNext();
      end
    end
    // Run the last instruction up to its closing fetch
    do begin
      @(posedge clk);
      #InputDelay;
    end while (!ctrl.irWrite);
    @(posedge clk);
    #InputDelay;
    if (checkFailed) begin
      stopWithFailure("a check failed during the run");
    end else begin
      $display("No errors");
      $finish;
    end
  end

  initial begin
    wait (checkFailed === 1'b1);
    stopWithFailure("stopped at the first failed check");
  end

  initial begin
    #(TimeoutNs);
    stopWithFailure("timeout: the instructions did not complete in the expected time");
  end

endmodule

// ==== build.f ====
verilog/isaPkg.sv
verilog/ctrlPkg.sv
verilog/instrDecoder.sv
verilog/stateSequencer.sv
verilog/controlEncoder.sv
verilog/controlUnit.sv
testbench/controlUnitProps.sv
testbench/controlUnitTb.sv

// ==== Makefile ====
TOP = controlUnitTb

sim:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f build.f
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -qx "No errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
